// ==== compile.f ====
+incdir+dv
hdl/stkclr_pkg.sv
hdl/lsu_req_if.sv
hdl/stkclr_csr.sv
hdl/stkclr_engine.sv
hdl/lsu_arbiter.sv
hdl/stack_ram.sv
hdl/stkclr_top.sv
dv/stkclr_tb.sv

// ==== dv/stkclr_tests.svh ====
// ======================================================================
// Directed tests for the stack-clear subsystem, included into the
// testbench top where the access and check tasks live
// ======================================================================

`ifndef STKCLR_TESTS_SVH
`define STKCLR_TESTS_SVH

task automatic test_basic_clear();
  logic [31:0] st;
  fill_random(32'h0C0, 32'h180);  // Filled before MSHWM is set, so no tracking
  csr_write(CSR_MSHWM, 32'h100);
  csr_write(CSR_STKCLR_PTR, 32'h140);
  wait_idle();
  model_zero(32'h100, 32'h140);
  check_range(32'h0C0, 32'h180);
  csr_read(CSR_STATUS, st);
  if (st !== 32'h0)
    report_value("csr_rdata_o STATUS", 32'h0, st);
endtask

task automatic test_no_start();
  logic [31:0] st;
  csr_write(CSR_STKCLR_PTR, 32'h100);  // Same as MSHWM
  repeat (3) begin
    csr_read(CSR_STATUS, st);
    if (st[0] !== 1'b0)
      report_problem("clear started with the pointer equal to MSHWM");
  end
  check_range(32'h0C0, 32'h180);
endtask

task automatic test_watermark();
  logic [31:0] hwm;
  csr_write(CSR_MSHWMB, 32'h080);
  csr_write(CSR_MSHWM, 32'h200);
  core_write(32'h1F0, $urandom);
  core_write(32'h300, $urandom);  // Above the watermark
  core_write(32'h040, $urandom);  // Below the base
  csr_read(CSR_MSHWM, hwm);
  if (hwm !== 32'h1F0)
    report_value("csr_rdata_o MSHWM", 32'h1F0, hwm);
endtask

task automatic test_core_priority();
  logic [31:0] st;
  fill_random(32'h1C0, 32'h2C0);
  csr_write(CSR_MSHWM, 32'h200);
  csr_write(CSR_STKCLR_PTR, 32'h280);
  csr_read(CSR_STATUS, st);
  if (st[0] !== 1'b1)
    report_problem("clear did not start for pointer 0x280");
  // Core traffic outside the cleared range while the engine runs
  for (int i = 0; i < 8; i++)
    core_write(32'h300 + 4 * i, $urandom);
  check_range(32'h300, 32'h320);
  wait_idle();
  model_zero(32'h200, 32'h280);
  check_range(32'h1C0, 32'h2C0);
endtask

task automatic test_abort();
  logic [31:0] st;
  logic [31:0] ptr;
  fill_random(32'h3C0, 32'h600);
  csr_write(CSR_MSHWM, 32'h400);
  csr_write(CSR_STKCLR_PTR, 32'h600);  // 128 words, far longer than the irq delay
  repeat (20) @(posedge clk_i);
  #1;
  irq_i = 1'b1;
  wait_idle();
  @(posedge clk_i);
  #1;
  irq_i = 1'b0;
  csr_read(CSR_STATUS, st);
  if (st !== ST_ABORT)
    report_value("csr_rdata_o STATUS", ST_ABORT, st);
  csr_read(CSR_STKCLR_PTR, ptr);
  core_read_check(32'h3C0);  // Any core access leaves ABORT
  csr_read(CSR_STATUS, st);
  if (st !== 32'h0)
    report_value("csr_rdata_o STATUS", 32'h0, st);
  if (ptr < 32'h400 || ptr >= 32'h600 || ptr[1:0] != 2'b00)
    report_problem($sformatf("abort pointer 0x%08h lies outside the cleared range", ptr));
  else
    model_zero(ptr, 32'h600);
  check_range(32'h3C0, 32'h600);
endtask

task automatic test_error_flag();
  logic [31:0] st;
  csr_write(CSR_MSHWM, RAM_DEPTH * 4);  // First byte past the RAM
  csr_write(CSR_STKCLR_PTR, RAM_DEPTH * 4 + 32'h40);
  wait_idle();
  csr_read(CSR_STATUS, st);
  if (st !== ST_ERR)
    report_value("csr_rdata_o STATUS", ST_ERR, st);
  fill_random(32'h100, 32'h110);
  csr_write(CSR_MSHWM, 32'h100);
  csr_write(CSR_STKCLR_PTR, 32'h108);
  wait_idle();
  csr_read(CSR_STATUS, st);
  if (st !== 32'h0)
    report_value("csr_rdata_o STATUS", 32'h0, st);
  model_zero(32'h100, 32'h108);
  check_range(32'h0F8, 32'h110);
endtask

`endif

// ==== dv/stkclr_tb.sv ====
// ======================================================================
// Testbench for the stack-clear subsystem, directed tests checked
// against a model memory that mirrors every core write
// ======================================================================

`timescale 1ns/1ps

module stkclr_tb;
  import stkclr_pkg::*;

  localparam int unsigned RAM_DEPTH  = 1024;
  localparam int unsigned MAX_CYCLES = 20000;  // About 1300 cycles of tests plus wide margin
  localparam logic [31:0] ST_ABORT   = 32'h2;
  localparam logic [31:0] ST_ERR     = 32'h4;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        csr_we_i;
  csr_addr_e   csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic        irq_i;
  logic        core_req_i;
  logic        core_we_i;
  logic [31:0] core_addr_i;
  logic [31:0] core_wdata_i;
  logic        core_done_o;
  logic        core_rvalid_o;
  logic [31:0] core_rdata_o;
  logic        core_err_o;

  logic [31:0] model [RAM_DEPTH];  // Expected RAM contents
  int unsigned err_cnt = 0;

  always #50 clk_i = ~clk_i;

  stkclr_top #(.RAM_DEPTH(RAM_DEPTH)) i_dut (.*);

  task automatic report_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    err_cnt++;
    $display("error %s: expected 0x%08h, got 0x%08h", sig, exp, act);
  endtask

  task automatic report_problem(input string msg);
    err_cnt++;
    $display("%s (at %0t)", msg, $time);
  endtask

  // Request held until done, response sampled in the following cycle
  task automatic core_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk_i);
    #1;
    core_req_i   = 1'b1;
    core_we_i    = we;
    core_addr_i  = addr;
    core_wdata_i = wdata;
    @(negedge clk_i);
    if (!core_done_o)
      report_problem("core request not accepted in its first cycle");
    while (!core_done_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    core_req_i = 1'b0;
    core_we_i  = 1'b0;
    @(negedge clk_i);
    if (!core_rvalid_o || core_err_o)
      report_problem($sformatf("core access to 0x%08h got no clean response", addr));
    rdata = core_rdata_o;
    if (we)
      model[addr >> 2] = wdata;
  endtask

  task automatic core_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    core_access(1'b1, addr, data, unused);
  endtask

  task automatic core_read_check(input logic [31:0] addr);
    logic [31:0] data;
    core_access(1'b0, addr, '0, data);
    if (data !== model[addr >> 2])
      report_value($sformatf("core_rdata_o @0x%08h", addr), model[addr >> 2], data);
  endtask

  task automatic fill_random(input logic [31:0] lo, input logic [31:0] hi);
    for (logic [31:0] a = lo; a < hi; a += 4)
      core_write(a, $urandom);
  endtask

  task automatic check_range(input logic [31:0] lo, input logic [31:0] hi);
    for (logic [31:0] a = lo; a < hi; a += 4)
      core_read_check(a);
  endtask

  // Expected effect of a clear over [lo, hi)
  task automatic model_zero(input logic [31:0] lo, input logic [31:0] hi);
    for (logic [31:0] a = lo; a < hi; a += 4)
      model[a >> 2] = '0;
  endtask

  task automatic csr_write(input csr_addr_e addr, input logic [31:0] data);
    @(posedge clk_i);
    #1;
    csr_we_i    = 1'b1;
    csr_addr_i  = addr;
    csr_wdata_i = data;
    @(posedge clk_i);
    #1;
    csr_we_i = 1'b0;
  endtask

  task automatic csr_read(input csr_addr_e addr, output logic [31:0] data);
    @(posedge clk_i);
    #1;
    csr_addr_i = addr;
    @(negedge clk_i);
    data = csr_rdata_o;
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    csr_read(CSR_STATUS, st);
    while (st[0] !== 1'b0)
      csr_read(CSR_STATUS, st);
  endtask

  `include "stkclr_tests.svh"

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d errors so far", MAX_CYCLES, err_cnt);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    void'($urandom(52606));
    rst_ni       = 1'b0;
    csr_we_i     = 1'b0;
    csr_addr_i   = CSR_MSHWM;
    csr_wdata_i  = '0;
    irq_i        = 1'b0;
    core_req_i   = 1'b0;
    core_we_i    = 1'b0;
    core_addr_i  = '0;
    core_wdata_i = '0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_basic_clear();
    test_no_start();
    test_watermark();
    test_core_priority();
    test_abort();
    test_error_flag();

    $display("run complete, %0d errors", err_cnt);
    if (err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== hdl/lsu_arbiter.sv ====
// ======================================================================
// Fixed-priority arbiter, core over stack clearer, onto one memory port
// Responses are steered back by the source granted one cycle earlier
// ======================================================================

`timescale 1ns/1ps

module lsu_arbiter (
  input  logic         clk_i,
  input  logic         rst_ni,

  lsu_req_if.memory    core,   // High priority
  lsu_req_if.memory    clr,    // Uses free cycles only
  lsu_req_if.requester mem
);

  logic core_gnt, clr_gnt;
  logic owner_core_q;

  assign core_gnt = core.req;
  assign clr_gnt  = clr.req && !core.req;

  // Forward the winner
  assign mem.req   = core_gnt || clr_gnt;
  assign mem.we    = core_gnt ? core.we    : clr.we;
  assign mem.addr  = core_gnt ? core.addr  : clr.addr;
  assign mem.wdata = core_gnt ? core.wdata : clr.wdata;

  // Only the winner sees its acceptance
  assign core.done = core_gnt && mem.done;
  assign clr.done  = clr_gnt && mem.done;

  // Response belongs to whoever was granted last cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      owner_core_q <= 1'b0;
    else
      owner_core_q <= core_gnt;
  end

  assign core.rvalid = mem.rvalid && owner_core_q;
  assign core.rdata  = owner_core_q ? mem.rdata : '0;
  assign core.err    = mem.err && owner_core_q;

  assign clr.rvalid  = mem.rvalid && !owner_core_q;
  assign clr.rdata   = owner_core_q ? '0 : mem.rdata;
  assign clr.err     = mem.err && !owner_core_q;

  a_single_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(core.done && clr.done));

  // Relies on the memory answering exactly one cycle after acceptance
  a_resp_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core.done || clr.done) |=> (core.rvalid || clr.rvalid));

endmodule

// ==== hdl/lsu_req_if.sv ====
// ======================================================================
// Load/store port with request/done handshake and a one-cycle response
// ======================================================================

`timescale 1ns/1ps

interface lsu_req_if;

  logic        req;     // Held with addr/wdata until done
  logic        we;
  logic [31:0] addr;    // Byte address
  logic [31:0] wdata;
  logic        done;    // Acceptance, same cycle as req
  logic        rvalid;  // One cycle after done
  logic [31:0] rdata;
  logic        err;     // Qualified by rvalid

  // Side that issues loads and stores
  modport requester (
    output req, we, addr, wdata,
    input  done, rvalid, rdata, err
  );

  // Side that accepts and answers them
  modport memory (
    input  req, we, addr, wdata,
    output done, rvalid, rdata, err
  );

endinterface

// ==== hdl/stack_ram.sv ====
// ======================================================================
// Single-port word RAM, accepts every request and answers one cycle later
// Addresses beyond the array return an error response with zero data
// ======================================================================

`timescale 1ns/1ps

module stack_ram #(
  parameter int unsigned RAM_DEPTH = 1024  // Words, power of two
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  lsu_req_if.memory lsu
);
  import stkclr_pkg::*;

  localparam int unsigned IDX_W = $clog2(RAM_DEPTH);

  logic [31:0]      mem_q [RAM_DEPTH];
  logic [IDX_W-1:0] word_idx;
  logic             in_range;
  logic             rvalid_q, err_q;
  logic [31:0]      rdata_q;

  assign word_idx = lsu.addr[WORD_LSB +: IDX_W];
  assign in_range = (lsu.addr[31:WORD_LSB+IDX_W] == '0);  // Upper word bits all clear

  assign lsu.done = lsu.req;  // No back-pressure

  // Array and read data
  always_ff @(posedge clk_i) begin
    if (lsu.req) begin
      if (in_range && lsu.we)
        mem_q[word_idx] <= lsu.wdata;

      if (in_range && !lsu.we)
        rdata_q <= mem_q[word_idx];
      else
        rdata_q <= '0;  // Writes and bad addresses return zero
    end
  end

  // Response flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= lsu.req;
      err_q    <= lsu.req && !in_range;
    end
  end

  assign lsu.rvalid = rvalid_q;
  assign lsu.rdata  = rdata_q;
  assign lsu.err    = err_q;

endmodule

// ==== hdl/stkclr_csr.sv ====
// ======================================================================
// CSR block for the stack watermark and the stack-clear controls
// Tracks core stores to lower MSHWM and hands pointer writes to the engine
// ======================================================================

`timescale 1ns/1ps

module stkclr_csr (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      csr_we_i,
  input  stkclr_pkg::csr_addr_e     csr_addr_i,
  input  logic [31:0]               csr_wdata_i,
  output logic [31:0]               csr_rdata_o,

  input  logic                      core_store_i,       // Core write accepted this cycle
  input  logic [31:0]               core_store_addr_i,

  output logic                      ptr_wr_o,
  output logic [31:0]               ptr_wdata_o,
  output logic [31:0]               mshwm_o,

  input  stkclr_pkg::stkclr_state_e state_i,
  input  logic [31:0]               ptr_i,
  input  logic                      err_i
);
  import stkclr_pkg::*;

  localparam int unsigned WW = 32 - WORD_LSB;  // Word address width

  logic [WW-1:0] mshwm_q, mshwmb_q;
  logic [WW-1:0] store_word;
  logic          mshwm_wr, mshwmb_wr;
  logic          lower;

  assign mshwm_wr   = csr_we_i && (csr_addr_i == CSR_MSHWM);
  assign mshwmb_wr  = csr_we_i && (csr_addr_i == CSR_MSHWMB);
  assign store_word = core_store_addr_i[31:WORD_LSB];

  // Store inside [MSHWMB, MSHWM) pulls the watermark down
  assign lower = core_store_i && (store_word >= mshwmb_q) && (store_word < mshwm_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mshwm_q  <= '0;
      mshwmb_q <= '0;
    end else begin
      if (mshwm_wr)
        mshwm_q <= csr_wdata_i[31:WORD_LSB];  // Software write wins over tracking
      else if (lower)
        mshwm_q <= store_word;

      if (mshwmb_wr)
        mshwmb_q <= csr_wdata_i[31:WORD_LSB];
    end
  end

  // Start request goes straight to the engine, it samples at the next edge
  assign ptr_wr_o    = csr_we_i && (csr_addr_i == CSR_STKCLR_PTR);
  assign ptr_wdata_o = csr_wdata_i;
  assign mshwm_o     = {mshwm_q, {WORD_LSB{1'b0}}};

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MSHWM:      csr_rdata_o = {mshwm_q, {WORD_LSB{1'b0}}};
      CSR_MSHWMB:     csr_rdata_o = {mshwmb_q, {WORD_LSB{1'b0}}};
      CSR_STKCLR_PTR: csr_rdata_o = ptr_i;
      CSR_STATUS: begin
        csr_rdata_o[0] = (state_i == STKCLR_ACTIVE);
        csr_rdata_o[1] = (state_i == STKCLR_ABORT);
        csr_rdata_o[2] = err_i;
      end
    endcase
  end

  // The CSR master writes for one cycle at a time, a longer write
  // would look like two starts to the engine
  a_ptr_wr_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ptr_wr_o |=> !ptr_wr_o);

endmodule

// ==== hdl/stkclr_engine.sv ====
// ======================================================================
// Stack-clear engine, writes zero words from the start pointer down to
// the captured watermark through a requester port behind the core
// ======================================================================

`timescale 1ns/1ps

module stkclr_engine (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      ptr_wr_i,      // Pointer CSR write strobe
  input  logic [31:0]               ptr_wdata_i,
  input  logic [31:0]               mshwm_i,

  input  logic                      irq_i,
  input  logic                      snoop_done_i,  // Any core access accepted

  lsu_req_if.requester              lsu,

  output stkclr_pkg::stkclr_state_e state_o,
  output logic [31:0]               ptr_o,
  output logic                      err_o
);
  import stkclr_pkg::*;

  localparam int unsigned WW = 32 - WORD_LSB;

  stkclr_state_e state_d, state_q;

  logic [WW-1:0] ptr_q;    // Last word written
  logic [WW-1:0] nxt_q;    // Word being requested
  logic [WW-1:0] base_q;   // Watermark captured at start
  logic          err_q;
  logic          start, active, accept, last, stop;

  assign active = (state_q == STKCLR_ACTIVE);
  assign accept = active && lsu.done;

  assign start = ptr_wr_i && (state_q == STKCLR_IDLE) && (ptr_wdata_i != mshwm_i);
  assign last  = accept && (nxt_q <= base_q);
  assign stop  = accept && irq_i && !last;  // Finishing beats aborting

  // Zero writes only
  assign lsu.req   = active;
  assign lsu.we    = 1'b1;
  assign lsu.addr  = {nxt_q, {WORD_LSB{1'b0}}};
  assign lsu.wdata = '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      STKCLR_IDLE: begin
        if (start)
          state_d = STKCLR_ACTIVE;
      end
      STKCLR_ACTIVE: begin
        if (last)
          state_d = STKCLR_IDLE;
        else if (stop)
          state_d = STKCLR_ABORT;
      end
      STKCLR_ABORT: begin
        if (snoop_done_i)
          state_d = STKCLR_IDLE;  // Cleared by the next core access
      end
      default: state_d = STKCLR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= STKCLR_IDLE;
      ptr_q   <= '0;
      nxt_q   <= '0;
      base_q  <= '0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;

      if (start) begin
        ptr_q  <= ptr_wdata_i[31:WORD_LSB];
        nxt_q  <= ptr_wdata_i[31:WORD_LSB] - WW'(1);
        base_q <= mshwm_i[31:WORD_LSB];
      end else if (accept) begin
        ptr_q <= nxt_q;
        if (!(last || stop))
          nxt_q <= nxt_q - WW'(1);
      end

      // Sticky, also catches the response to the final write
      if (start)
        err_q <= 1'b0;
      else if (lsu.rvalid && lsu.err)
        err_q <= 1'b1;
    end
  end

  assign state_o = state_q;
  assign ptr_o   = {ptr_q, {WORD_LSB{1'b0}}};
  assign err_o   = err_q;

  // No further write once the final or aborting word is taken
  a_req_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (accept && (last || stop)) |=> !lsu.req);

  // Under core back-pressure the write stays put until the arbiter takes it
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lsu.req && !lsu.done) |=> (lsu.req && $stable(lsu.addr)));

endmodule

// ==== hdl/stkclr_pkg.sv ====
// ======================================================================
// Shared types and constants for the stack-clearing subsystem
// Imported by the CSR block, the clear engine, the RAM and the top level
// ======================================================================

package stkclr_pkg;

  // CSR map, one register per address
  typedef enum logic [1:0] {
    CSR_MSHWM      = 2'd0,  // Stack high watermark
    CSR_MSHWMB     = 2'd1,  // Watermark base, lowest tracked stack address
    CSR_STKCLR_PTR = 2'd2,  // Write starts a clear, read gives the progress pointer
    CSR_STATUS     = 2'd3   // {err, abort, active}
  } csr_addr_e;

  // Clear engine states
  typedef enum logic [1:0] {
    STKCLR_IDLE   = 2'd0,
    STKCLR_ACTIVE = 2'd1,
    STKCLR_ABORT  = 2'd2
  } stkclr_state_e;

  // Byte-offset bits dropped to form a word address
  localparam int unsigned WORD_LSB = 2;

endpackage

// ==== hdl/stkclr_top.sv ====
// ======================================================================
// Stack-clear subsystem top, core load/store port and CSR port in,
// clear engine and core share one data RAM through the arbiter
// ======================================================================

`timescale 1ns/1ps

module stkclr_top #(
  parameter int unsigned RAM_DEPTH = 1024
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // CSR access
  input  logic                  csr_we_i,
  input  stkclr_pkg::csr_addr_e csr_addr_i,
  input  logic [31:0]           csr_wdata_i,
  output logic [31:0]           csr_rdata_o,

  input  logic                  irq_i,

  // Core load/store port
  input  logic                  core_req_i,
  input  logic                  core_we_i,
  input  logic [31:0]           core_addr_i,
  input  logic [31:0]           core_wdata_i,
  output logic                  core_done_o,
  output logic                  core_rvalid_o,
  output logic [31:0]           core_rdata_o,
  output logic                  core_err_o
);
  import stkclr_pkg::*;

  lsu_req_if core_lsu ();
  lsu_req_if clr_lsu ();
  lsu_req_if mem_lsu ();

  stkclr_state_e state;
  logic          ptr_wr;
  logic [31:0]   ptr_wdata, mshwm, clr_ptr;
  logic          clr_err;
  logic          core_store;

  assign core_lsu.req   = core_req_i;
  assign core_lsu.we    = core_we_i;
  assign core_lsu.addr  = core_addr_i;
  assign core_lsu.wdata = core_wdata_i;

  assign core_done_o   = core_lsu.done;
  assign core_rvalid_o = core_lsu.rvalid;
  assign core_rdata_o  = core_lsu.rdata;
  assign core_err_o    = core_lsu.err;

  assign core_store = core_lsu.done && core_lsu.we;  // Feeds watermark tracking

  stkclr_csr u_csr (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .csr_we_i          (csr_we_i),
    .csr_addr_i        (csr_addr_i),
    .csr_wdata_i       (csr_wdata_i),
    .csr_rdata_o       (csr_rdata_o),
    .core_store_i      (core_store),
    .core_store_addr_i (core_addr_i),
    .ptr_wr_o          (ptr_wr),
    .ptr_wdata_o       (ptr_wdata),
    .mshwm_o           (mshwm),
    .state_i           (state),
    .ptr_i             (clr_ptr),
    .err_i             (clr_err)
  );

  stkclr_engine u_engine (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ptr_wr_i     (ptr_wr),
    .ptr_wdata_i  (ptr_wdata),
    .mshwm_i      (mshwm),
    .irq_i        (irq_i),
    .snoop_done_i (core_lsu.done),
    .lsu          (clr_lsu.requester),
    .state_o      (state),
    .ptr_o        (clr_ptr),
    .err_o        (clr_err)
  );

  lsu_arbiter u_arbiter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .core   (core_lsu.memory),
    .clr    (clr_lsu.memory),
    .mem    (mem_lsu.requester)
  );

  stack_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .lsu    (mem_lsu.memory)
  );

endmodule
